//--- focus_mem.sv
// Focus point memory with one write port and a two-cycle registered read
`timescale 1ns/1ps

module focus_mem
  import stm_pkg::*;
(
  input  logic                    CLK,
  input  logic                    wr_en,
  input  logic [FOCUS_ADDR_W-1:0] wr_addr,
  input  focus_word_t             wr_data,
  input  logic [FOCUS_ADDR_W-1:0] rd_addr,
  output focus_word_t             rd_data
);

  focus_word_t mem [FOCUS_DEPTH];

  logic [FOCUS_ADDR_W-1:0] rd_addr_q;

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Address stage then data stage; same-entry write reads old data
  always_ff @(posedge CLK) begin
    rd_addr_q <= rd_addr;
    rd_data   <= mem[rd_addr_q];
  end

endmodule

//--- focus_operator.sv
// Focus operator FSM with squared distance, iterative square root, divider and outputs
`timescale 1ns/1ps

module focus_operator
  import stm_pkg::*;
(
  input  logic                    CLK,
  input  logic                    rst,
  input  logic                    update,
  input  logic [FOCUS_ADDR_W-1:0] focus_idx,
  input  logic [SPEED_W-1:0]      sound_speed,
  input  focus_word_t             rd_data,
  output logic [FOCUS_ADDR_W-1:0] rd_addr,
  output logic [PHASE_W-1:0]      duty,
  output logic [PHASE_W-1:0]      phase,
  output logic [TRANS_IDX_W-1:0]  trans_idx,
  output logic                    dout_valid,
  output logic                    busy
);

  logic [ST_W-1:0]       state;
  logic [STEP_CNT_W-1:0] step_cnt;
  logic [SPEED_W-1:0]    speed_q;
  focus_word_t           focus_q;

  logic signed [DELTA_W-1:0]   dx, dy;
  logic signed [DIST_SQ_W-1:0] dx_e, dy_e, dz_e;
  logic [DIST_SQ_W-1:0]        dist_sq;
  logic [DIST_SQ_W-1:0]        d2_q;      // Radicand, consumed two bits per step

  logic [SQRT_REM_W-1:0] sq_rem, sq_shift, sq_next;
  logic [SQRT_W-1:0]     sq_root, root_next;

  logic [SPEED_W-1:0]    div_rem;
  logic [DIV_W-1:0]      div_quo, quo_next, dividend;
  logic [SPEED_W:0]      div_shift;
  logic [SPEED_W+1:0]    div_trial;
  logic                  div_ok;

  // Squared distance for the current transducer
  always_comb begin
    dx      = DELTA_W'(focus_q.fields.x) - DELTA_W'(trans_pos_x(trans_idx));
    dy      = DELTA_W'(focus_q.fields.y) - DELTA_W'(trans_pos_y(trans_idx));
    dx_e    = DIST_SQ_W'(dx);
    dy_e    = DIST_SQ_W'(dy);
    dz_e    = DIST_SQ_W'(focus_q.fields.z);
    dist_sq = dx_e * dx_e + dy_e * dy_e + dz_e * dz_e;
  end

  // Non-restoring square root step, sign of remainder picks add or subtract
  always_comb begin
    sq_shift = {sq_rem[SQRT_REM_W-3:0], d2_q[DIST_SQ_W-1 -: 2]};
    if (sq_rem[SQRT_REM_W-1]) begin
      sq_next = sq_shift + SQRT_REM_W'({sq_root, 2'b11});
    end else begin
      sq_next = sq_shift - SQRT_REM_W'({sq_root, 2'b01});
    end
    root_next = {sq_root[SQRT_W-2:0], ~sq_next[SQRT_REM_W-1]};
    dividend  = DIV_W'(root_next) << PHASE_SCALE_SHIFT;
  end

  // Restoring divide step
  always_comb begin
    div_shift = {div_rem, div_quo[DIV_W-1]};
    div_trial = {1'b0, div_shift} - {2'b00, speed_q};
    div_ok    = ~div_trial[SPEED_W+1];
    quo_next  = {div_quo[DIV_W-2:0], div_ok};
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      state      <= ST_WAITING;
      busy       <= 1'b0;
      dout_valid <= 1'b0;
      trans_idx  <= '0;
      step_cnt   <= '0;
    end else begin
      dout_valid <= 1'b0;
      case (state)
        ST_WAITING: begin
          if (update) begin  // busy is low here
            busy  <= 1'b1;
            state <= ST_MEM_WAIT_0;
          end
        end
        ST_MEM_WAIT_0: state <= ST_MEM_WAIT_1;
        ST_MEM_WAIT_1: state <= ST_LOAD;
        ST_LOAD: begin
          trans_idx <= '0;
          state     <= ST_SQUARE;
        end
        ST_SQUARE: begin
          step_cnt <= '0;
          state    <= ST_SQRT;
        end
        ST_SQRT: begin
          step_cnt <= step_cnt + 1'b1;
          if (step_cnt == STEP_CNT_W'(SQRT_W - 1)) begin
            step_cnt <= '0;
            state    <= ST_DIVIDE;
          end
        end
        ST_DIVIDE: begin
          step_cnt <= step_cnt + 1'b1;  // Wraps to zero after the last step
          if (step_cnt == STEP_CNT_W'(DIV_W - 1)) begin
            dout_valid <= 1'b1;
            state      <= ST_EMIT;
          end
        end
        ST_EMIT: begin
          if (trans_idx == TRANS_IDX_W'(NUM_TRANS - 1)) begin
            busy  <= 1'b0;
            state <= ST_WAITING;
          end else begin
            trans_idx <= trans_idx + 1'b1;
            state     <= ST_SQUARE;
          end
        end
        default: state <= ST_WAITING;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    case (state)
      ST_WAITING: begin
        if (update) begin
          rd_addr <= focus_idx;
          speed_q <= sound_speed;
        end
      end
      ST_LOAD: focus_q <= rd_data;
      ST_SQUARE: begin
        d2_q    <= dist_sq;
        sq_rem  <= '0;
        sq_root <= '0;
      end
      ST_SQRT: begin
        d2_q    <= d2_q << 2;
        sq_rem  <= sq_next;
        sq_root <= root_next;
        div_rem <= '0;
        div_quo <= dividend;  // Last step leaves the final root here
      end
      ST_DIVIDE: begin
        div_rem <= div_ok ? div_trial[SPEED_W-1:0] : div_shift[SPEED_W-1:0];
        div_quo <= quo_next;
        phase   <= (speed_q == '0) ? '0 : quo_next[PHASE_W-1:0];  // Mod 512
        duty    <= PHASE_W'(DUTY_FULL) >> focus_q.fields.duty_shift;
      end
      default: ;
    endcase
  end

  valid_in_busy: assert property (
    @(posedge CLK) disable iff (rst) dout_valid |-> busy
  );

endmodule

//--- focus_wb_port.sv
// Wishbone classic slave that builds focus words from two 32-bit writes
`timescale 1ns/1ps

module focus_wb_port
  import stm_pkg::*;
(
  input  logic                    CLK,
  input  logic                    rst,
  input  logic                    cyc,
  input  logic                    stb,
  input  logic                    we,
  input  logic [WB_ADDR_W-1:0]    adr,
  input  logic [31:0]             dat_w,
  input  logic [3:0]              sel,
  output logic                    ack,
  output logic [31:0]             dat_r,
  output logic                    wr_en,
  output logic [FOCUS_ADDR_W-1:0] wr_addr,
  output focus_word_t             wr_data
);

  focus_word_t hold;
  logic [31:0] merged;
  logic        req;

  assign req = cyc && stb && !ack;  // New access, not yet acked

  // Byte lanes merged over the addressed half
  always_comb begin
    merged = hold.words[adr[0]];
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        merged[8*b +: 8] = dat_w[8*b +: 8];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      ack   <= 1'b0;
      wr_en <= 1'b0;
    end else begin
      ack   <= req;
      wr_en <= req && we && adr[0];  // High half commits the entry
    end
  end

  always_ff @(posedge CLK) begin
    if (req && we) begin
      hold.words[adr[0]] <= merged;
    end
    if (req && we && adr[0]) begin
      wr_addr <= adr[WB_ADDR_W-1:1];
    end
  end

  assign wr_data = hold;  // Stable through the ack cycle
  assign dat_r   = '0;    // No read-back

  ack_needs_cyc: assert property (
    @(posedge CLK) disable iff (rst) ack |-> cyc
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_stm_top -o tb_stm_top
./obj_dir/tb_stm_top | tee sim.log

if grep -qx '>>> PASS' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

//--- stm_pkg.sv
// Sizes, FSM state codes, focus word union and transducer position functions
package stm_pkg;

  localparam int NUM_TRANS         = 8;
  localparam int TRANS_IDX_W       = 3;
  localparam int FOCUS_DEPTH       = 16;
  localparam int FOCUS_ADDR_W      = 4;
  localparam int WB_ADDR_W         = 5;   // Entry in [4:1], half in [0]
  localparam int COORD_W           = 18;
  localparam int PHASE_W           = 9;
  localparam int DUTY_FULL         = 256;
  localparam int PHASE_SCALE_SHIFT = 6;
  localparam int SPEED_W           = 16;

  localparam int GRID_COLS   = 4;
  localparam int TRANS_PITCH = 100;
  localparam int DELTA_W     = COORD_W + 1;   // Focus minus position, no overflow
  localparam int DIST_SQ_W   = 38;
  localparam int SQRT_W      = 19;
  localparam int SQRT_REM_W  = 24;            // Signed partial remainder
  localparam int DIV_W       = 32;            // Dividend width and step count
  localparam int STEP_CNT_W  = 5;

  // Operator FSM encoding
  localparam int ST_W = 3;
  localparam logic [ST_W-1:0] ST_WAITING    = 3'd0;
  localparam logic [ST_W-1:0] ST_MEM_WAIT_0 = 3'd1;
  localparam logic [ST_W-1:0] ST_MEM_WAIT_1 = 3'd2;
  localparam logic [ST_W-1:0] ST_LOAD       = 3'd3;
  localparam logic [ST_W-1:0] ST_SQUARE     = 3'd4;
  localparam logic [ST_W-1:0] ST_SQRT       = 3'd5;
  localparam logic [ST_W-1:0] ST_DIVIDE     = 3'd6;
  localparam logic [ST_W-1:0] ST_EMIT       = 3'd7;

  typedef union packed {
    logic [1:0][31:0] words;        // Bus view, [0] is the low half
    struct packed {
      logic [5:0]                unused;
      logic [3:0]                duty_shift;
      logic signed [COORD_W-1:0] z;
      logic signed [COORD_W-1:0] y;
      logic signed [COORD_W-1:0] x;
    } fields;                       // Operator view
  } focus_word_t;

  function automatic logic signed [COORD_W-1:0] trans_pos_x(input logic [TRANS_IDX_W-1:0] idx);
    return COORD_W'((int'(idx) % GRID_COLS) * TRANS_PITCH);
  endfunction

  function automatic logic signed [COORD_W-1:0] trans_pos_y(input logic [TRANS_IDX_W-1:0] idx);
    return COORD_W'((int'(idx) / GRID_COLS) * TRANS_PITCH);
  endfunction

endpackage

//--- stm_top.sv
// Top level joining the Wishbone port, focus memory and focus operator
`timescale 1ns/1ps

module stm_top
  import stm_pkg::*;
(
  input  logic                    CLK,
  input  logic                    rst,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [WB_ADDR_W-1:0]    wb_adr,
  input  logic [31:0]             wb_dat_w,
  input  logic [3:0]              wb_sel,
  input  logic                    update,
  input  logic [FOCUS_ADDR_W-1:0] focus_idx,
  input  logic [SPEED_W-1:0]      sound_speed,
  output logic                    wb_ack,
  output logic [31:0]             wb_dat_r,
  output logic [PHASE_W-1:0]      duty,
  output logic [PHASE_W-1:0]      phase,
  output logic [TRANS_IDX_W-1:0]  trans_idx,
  output logic                    dout_valid,
  output logic                    busy
);

  logic                    wr_en;
  logic [FOCUS_ADDR_W-1:0] wr_addr;
  focus_word_t             wr_data;
  logic [FOCUS_ADDR_W-1:0] rd_addr;
  focus_word_t             rd_data;

  focus_wb_port port_i (
    .CLK     (CLK),
    .rst     (rst),
    .cyc     (wb_cyc),
    .stb     (wb_stb),
    .we      (wb_we),
    .adr     (wb_adr),
    .dat_w   (wb_dat_w),
    .sel     (wb_sel),
    .ack     (wb_ack),
    .dat_r   (wb_dat_r),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  focus_mem mem_i (
    .CLK     (CLK),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  focus_operator op_i (
    .CLK         (CLK),
    .rst         (rst),
    .update      (update),
    .focus_idx   (focus_idx),
    .sound_speed (sound_speed),
    .rd_data     (rd_data),
    .rd_addr     (rd_addr),
    .duty        (duty),
    .phase       (phase),
    .trans_idx   (trans_idx),
    .dout_valid  (dout_valid),
    .busy        (busy)
  );

endmodule

//--- tb_stm_ref.svh
// Reference duty and phase model, and typed compare tasks for the stm_top testbench
`ifndef TB_STM_REF_SVH
`define TB_STM_REF_SVH

// Expected outputs for one transducer, straight from the focus rules
function automatic void ref_duty_phase(
  input  focus_word_t            f,
  input  logic [TRANS_IDX_W-1:0] idx,
  input  logic [SPEED_W-1:0]     speed,
  output logic [PHASE_W-1:0]     exp_duty,
  output logic [PHASE_W-1:0]     exp_phase
);
  longint dx, dy, dz, d2, root, trial, quo;
  int     b;
  dx = longint'($signed(f.fields.x)) - longint'(trans_pos_x(idx));
  dy = longint'($signed(f.fields.y)) - longint'(trans_pos_y(idx));
  dz = longint'($signed(f.fields.z));
  d2 = dx * dx + dy * dy + dz * dz;
  root = 0;
  for (b = 18; b >= 0; b--) begin  // Largest root whose square fits in d2
    trial = root | (longint'(1) << b);
    if (trial * trial <= d2) begin
      root = trial;
    end
  end
  exp_duty = PHASE_W'(DUTY_FULL >> f.fields.duty_shift);
  if (speed == '0) begin
    exp_phase = '0;
  end else begin
    quo       = (root << PHASE_SCALE_SHIFT) / longint'(speed);
    exp_phase = PHASE_W'(quo % 512);
  end
endfunction

task automatic check_duty(input string what, input logic [PHASE_W-1:0] expected,
                          input logic [PHASE_W-1:0] actual);
  if (actual !== expected) begin
    $display("FAILED %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
    err_cnt++;
  end
endtask

task automatic check_phase(input string what, input logic [PHASE_W-1:0] expected,
                           input logic [PHASE_W-1:0] actual);
  if (actual !== expected) begin
    $display("FAILED %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
    err_cnt++;
  end
endtask

task automatic check_idx(input string what, input logic [TRANS_IDX_W-1:0] expected,
                         input logic [TRANS_IDX_W-1:0] actual);
  if (actual !== expected) begin
    $display("FAILED %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
    err_cnt++;
  end
endtask

task automatic check_data(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
  if (actual !== expected) begin
    $display("FAILED %s %s: expected %h, actual %h", cur_test, what, expected, actual);
    err_cnt++;
  end
endtask

task automatic check_flag(input string what, input logic expected, input logic actual);
  if (actual !== expected) begin
    $display("FAILED %s %s: expected %b, actual %b", cur_test, what, expected, actual);
    err_cnt++;
  end
endtask

`endif

//--- tb_stm_top.sv
// Testbench for stm_top with Wishbone driver, update sequencing, result collector and timeout
`timescale 1ns/1ps

module tb_stm_top
  import stm_pkg::*;
();

  localparam int NUM_UPDATES    = 18;
  localparam int TIMEOUT_CYCLES = NUM_UPDATES * (NUM_TRANS * 60 + 10) + 2000;

  logic                    CLK;
  logic                    rst;
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic [WB_ADDR_W-1:0]    wb_adr;
  logic [31:0]             wb_dat_w;
  logic [3:0]              wb_sel;
  logic                    update;
  logic [FOCUS_ADDR_W-1:0] focus_idx;
  logic [SPEED_W-1:0]      sound_speed;
  logic                    wb_ack;
  logic [31:0]             wb_dat_r;
  logic [PHASE_W-1:0]      duty;
  logic [PHASE_W-1:0]      phase;
  logic [TRANS_IDX_W-1:0]  trans_idx;
  logic                    dout_valid;
  logic                    busy;

  focus_word_t        shadow [FOCUS_DEPTH];  // What each entry should hold
  focus_word_t        exp_focus;
  logic [SPEED_W-1:0] exp_speed;
  logic [PHASE_W-1:0] ref_duty, ref_phase, last_duty;
  int                 res_count;
  string              cur_test;
  int                 err_cnt, test_err_base, tests_run, tests_failed;
  int                 cycle_cnt;
  integer             seed;

  `include "tb_stm_ref.svh"

  initial CLK = 1'b0;
  always #5 CLK = ~CLK;

  stm_top dut_i (
    .CLK         (CLK),
    .rst         (rst),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_sel      (wb_sel),
    .update      (update),
    .focus_idx   (focus_idx),
    .sound_speed (sound_speed),
    .wb_ack      (wb_ack),
    .wb_dat_r    (wb_dat_r),
    .duty        (duty),
    .phase       (phase),
    .trans_idx   (trans_idx),
    .dout_valid  (dout_valid),
    .busy        (busy)
  );

  initial cycle_cnt = 0;
  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout in %s after %0d cycles, DUT stopped responding", cur_test, cycle_cnt);
      $display(">>> FAIL");
      $finish;
    end
  end

  // Result collector, sampled mid-cycle
  always @(negedge CLK) begin
    if (!rst && dout_valid) begin
      if (res_count >= NUM_TRANS) begin
        flag_error($sformatf("extra result for transducer %0d after eight", trans_idx));
      end else begin
        ref_duty_phase(exp_focus, TRANS_IDX_W'(res_count), exp_speed, ref_duty, ref_phase);
        check_idx($sformatf("index of result %0d", res_count), TRANS_IDX_W'(res_count),
                  trans_idx);
        check_duty($sformatf("duty of transducer %0d", res_count), ref_duty, duty);
        check_phase($sformatf("phase of transducer %0d", res_count), ref_phase, phase);
      end
      last_duty = duty;
      res_count = res_count + 1;
    end
  end

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic flag_error(input string msg);
    $display("ERROR %s: %s", cur_test, msg);
    err_cnt++;
  endtask

  task automatic begin_test(input string name);
    cur_test      = name;
    test_err_base = err_cnt;
  endtask

  task automatic end_test();
    tests_run++;
    if (err_cnt == test_err_base) begin
      $display("%s: passed", cur_test);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", cur_test, err_cnt - test_err_base);
    end
  endtask

  // One classic cycle, ends once ack has been seen
  task automatic wb_access(input logic we, input logic [WB_ADDR_W-1:0] adr,
                           input logic [31:0] data, output logic [31:0] rdata);
    int waited;
    waited   = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = data;
    wb_sel   = 4'hf;
    do begin
      next_cycle();
      waited++;
    end while (!wb_ack && waited < 16);
    if (!wb_ack) begin
      flag_error($sformatf("no ack from the Wishbone port for address %0d", adr));
    end
    rdata  = wb_dat_r;
    next_cycle();  // Strobe held until the ack edge
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    next_cycle();
  endtask

  task automatic wb_write(input logic [WB_ADDR_W-1:0] adr, input logic [31:0] data);
    logic [31:0] unused_rd;
    wb_access(1'b1, adr, data, unused_rd);
  endtask

  task automatic write_focus(input logic [FOCUS_ADDR_W-1:0] idx, input focus_word_t w);
    wb_write({idx, 1'b0}, w.words[0]);
    wb_write({idx, 1'b1}, w.words[1]);
    shadow[idx] = w;
  endtask

  function automatic focus_word_t make_focus(input int x, input int y, input int z,
                                             input int shift);
    focus_word_t w;
    w                   = '0;
    w.fields.x          = COORD_W'(x);
    w.fields.y          = COORD_W'(y);
    w.fields.z          = COORD_W'(z);
    w.fields.duty_shift = 4'(shift);
    return w;
  endfunction

  task automatic start_update(input logic [FOCUS_ADDR_W-1:0] idx,
                              input logic [SPEED_W-1:0] speed);
    exp_focus   = shadow[idx];
    exp_speed   = speed;
    res_count   = 0;
    focus_idx   = idx;
    sound_speed = speed;
    update      = 1'b1;
    next_cycle();
    update = 1'b0;
  endtask

  task automatic finish_update();
    while (busy) begin
      next_cycle();
    end
    if (res_count != NUM_TRANS) begin
      flag_error($sformatf("got %0d results for one update instead of %0d", res_count,
                           NUM_TRANS));
    end
  endtask

  task automatic run_update(input logic [FOCUS_ADDR_W-1:0] idx,
                            input logic [SPEED_W-1:0] speed);
    start_update(idx, speed);
    finish_update();
  endtask

  initial begin
    focus_word_t w;
    logic [31:0] rd_word;
    int          i;
    seed        = 96565;
    rst         = 1'b1;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    wb_sel      = '0;
    update      = 1'b0;
    focus_idx   = '0;
    sound_speed = '0;
    err_cnt     = 0;
    tests_run   = 0;
    tests_failed = 0;
    res_count   = 0;
    exp_focus   = '0;
    exp_speed   = '0;
    last_duty   = '0;
    cur_test    = "reset";
    for (i = 0; i < FOCUS_DEPTH; i++) begin
      shadow[i] = '0;
    end
    repeat (5) @(posedge CLK);
    #1 rst = 1'b0;

    begin_test("reset_and_first_update");
    check_flag("wb_ack after reset", 1'b0, wb_ack);
    check_flag("dout_valid after reset", 1'b0, dout_valid);
    check_flag("busy after reset", 1'b0, busy);
    write_focus(4'd0, make_focus(0, 0, 500, 0));  // Straight above transducer 0
    run_update(4'd0, 16'd340);
    check_duty("duty at shift 0", 9'd256, last_duty);
    end_test();

    begin_test("negative_coords_and_wrap");
    write_focus(4'd1, make_focus(-250, -120, 800, 1));
    write_focus(4'd2, make_focus(-3000, -4000, 20000, 8));
    run_update(4'd1, 16'd343);
    check_duty("duty at shift 1", 9'd128, last_duty);
    run_update(4'd2, 16'd3);  // Quotient far above 511
    check_duty("duty at shift 8", 9'd1, last_duty);
    end_test();

    begin_test("entry_select");
    write_focus(4'd3, make_focus(120, 40, 900, 0));
    write_focus(4'd7, make_focus(-600, 350, 2500, 3));
    write_focus(4'd11, make_focus(10000, -7000, 64000, 5));
    run_update(4'd7, 16'd300);
    run_update(4'd3, 16'd500);
    run_update(4'd11, 16'd1000);
    end_test();

    begin_test("random_points");
    for (i = 0; i < 10; i++) begin
      w.words[0] = $random(seed);
      w.words[1] = $random(seed);
      write_focus(4'(i + 4), w);
      run_update(4'(i + 4), SPEED_W'($random(seed)));
    end
    end_test();

    begin_test("update_during_busy");
    start_update(4'd0, 16'd340);
    repeat (20) next_cycle();
    check_flag("busy at second pulse", 1'b1, busy);
    focus_idx   = 4'd2;
    sound_speed = 16'd7;
    update      = 1'b1;
    next_cycle();
    update = 1'b0;
    finish_update();
    repeat (5) next_cycle();
    check_flag("busy after ignored update", 1'b0, busy);
    end_test();

    begin_test("read_no_effect");
    write_focus(4'd14, make_focus(150, 50, 1200, 2));
    wb_access(1'b0, {4'd14, 1'b0}, 32'hffff_ffff, rd_word);
    check_data("read of low half", 32'h0, rd_word);
    wb_access(1'b0, {4'd14, 1'b1}, 32'hffff_ffff, rd_word);
    check_data("read of high half", 32'h0, rd_word);
    run_update(4'd14, 16'd1480);
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+.
stm_pkg.sv
focus_wb_port.sv
focus_mem.sv
focus_operator.sv
stm_top.sv
tb_stm_top.sv
